// File: rtl/cpuPkg.sv
package cpuPkg;

typedef logic [7:0] dataLogic;
typedef logic [15:0] addrLogic;

// documented mnemonics first, then the illegal ones
typedef enum logic [6:0] {
	ADC, AND, ASL, BCC, BCS, BEQ, BIT, BMI,
	BNE, BPL, BRK, BVC, BVS, CLC, CLD, CLI,
	CLV, CMP, CPX, CPY, DEC, DEX, DEY, EOR,
	INC, INX, INY, JMP, JSR, LDA, LDX, LDY,
	LSR, NOP, ORA, PHA, PHP, PLA, PLP, ROL,
	ROR, RTI, RTS, SBC, SEC, SED, SEI, STA,
	STX, STY, TAX, TAY, TSX, TXA, TXS, TYA,
	AHX, ALR, ANC, ARR, AXS, DCP, ISC, LAS,
	LAX, RLA, RRA, SAX, SHX, SHY, SLO, SRE,
	TAS, XAA,
	KIL	// jams the cpu
} Opcode;

typedef enum logic [3:0] {
	Imp,
	Imm,
	Ind,
	IndX,
	IndY,
	Zpg,
	ZpgX,
	ZpgY,
	Abs,
	AbsX,
	AbsY,
	Rlt
} Addressing;

localparam addrLogic resetPc = 16'h0200;	// no vector fetch

endpackage

// File: rtl/idec.sv
`timescale 1ns/1ps

module idec (
	input cpuPkg::dataLogic ins,
	output cpuPkg::Opcode opcode,
	output cpuPkg::Addressing mode,
	output logic [1:0] pcBytes
);

import cpuPkg::*;

localparam Opcode opTable [256] = '{
	BRK, ORA, KIL, SLO, NOP, ORA, ASL, SLO, PHP, ORA, ASL, ANC, NOP, ORA, ASL, SLO,	// 0x00
	BPL, ORA, KIL, SLO, NOP, ORA, ASL, SLO, CLC, ORA, NOP, SLO, NOP, ORA, ASL, SLO,
	JSR, AND, KIL, RLA, BIT, AND, ROL, RLA, PLP, AND, ROL, ANC, BIT, AND, ROL, RLA,
	BMI, AND, KIL, RLA, NOP, AND, ROL, RLA, SEC, AND, NOP, RLA, NOP, AND, ROL, RLA,
	RTI, EOR, KIL, SRE, NOP, EOR, LSR, SRE, PHA, EOR, LSR, ALR, JMP, EOR, LSR, SRE,	// 0x40
	BVC, EOR, KIL, SRE, NOP, EOR, LSR, SRE, CLI, EOR, NOP, SRE, NOP, EOR, LSR, SRE,
	RTS, ADC, KIL, RRA, NOP, ADC, ROR, RRA, PLA, ADC, ROR, ARR, JMP, ADC, ROR, RRA,
	BVS, ADC, KIL, RRA, NOP, ADC, ROR, RRA, SEI, ADC, NOP, RRA, NOP, ADC, ROR, RRA,
	NOP, STA, NOP, SAX, STY, STA, STX, SAX, DEY, NOP, TXA, XAA, STY, STA, STX, SAX,	// 0x80
	BCC, STA, KIL, AHX, STY, STA, STX, SAX, TYA, STA, TXS, TAS, SHY, STA, SHX, AHX,
	LDY, LDA, LDX, LAX, LDY, LDA, LDX, LAX, TAY, LDA, TAX, LAX, LDY, LDA, LDX, LAX,
	BCS, LDA, KIL, LAX, LDY, LDA, LDX, LAX, CLV, LDA, TSX, LAS, LDY, LDA, LDX, LAX,
	CPY, CMP, NOP, DCP, CPY, CMP, DEC, DCP, INY, CMP, DEX, AXS, CPY, CMP, DEC, DCP,	// 0xc0
	BNE, CMP, KIL, DCP, NOP, CMP, DEC, DCP, CLD, CMP, NOP, DCP, NOP, CMP, DEC, DCP,
	CPX, SBC, NOP, ISC, CPX, SBC, INC, ISC, INX, SBC, NOP, SBC, CPX, SBC, INC, ISC,
	BEQ, SBC, KIL, ISC, NOP, SBC, INC, ISC, SED, SBC, NOP, ISC, NOP, SBC, INC, ISC
};

// same row layout as opTable, 16 opcodes per row
localparam Addressing modeTable [256] = '{
	Imp, IndX, Imp, IndX, Zpg, Zpg, Zpg, Zpg, Imp, Imm, Imp, Imm, Abs, Abs, Abs, Abs,
	Rlt, IndY, Imp, IndY, ZpgX, ZpgX, ZpgX, ZpgX, Imp, AbsY, Imp, AbsY, AbsX, AbsX, AbsX, AbsX,
	Abs, IndX, Imp, IndX, Zpg, Zpg, Zpg, Zpg, Imp, Imm, Imp, Imm, Abs, Abs, Abs, Abs,
	Rlt, IndY, Imp, IndY, ZpgX, ZpgX, ZpgX, ZpgX, Imp, AbsY, Imp, AbsY, AbsX, AbsX, AbsX, AbsX,
	Imp, IndX, Imp, IndX, Zpg, Zpg, Zpg, Zpg, Imp, Imm, Imp, Imm, Abs, Abs, Abs, Abs,
	Rlt, IndY, Imp, IndY, ZpgX, ZpgX, ZpgX, ZpgX, Imp, AbsY, Imp, AbsY, AbsX, AbsX, AbsX, AbsX,
	Imp, IndX, Imp, IndX, Zpg, Zpg, Zpg, Zpg, Imp, Imm, Imp, Imm, Ind, Abs, Abs, Abs,
	Rlt, IndY, Imp, IndY, ZpgX, ZpgX, ZpgX, ZpgX, Imp, AbsY, Imp, AbsY, AbsX, AbsX, AbsX, AbsX,
	Imm, IndX, Imm, IndX, Zpg, Zpg, Zpg, Zpg, Imp, Imm, Imp, Imm, Abs, Abs, Abs, Abs,
	Rlt, IndY, Imp, IndY, ZpgX, ZpgX, ZpgY, ZpgY, Imp, AbsY, Imp, AbsY, AbsX, AbsX, AbsY, AbsY,
	Imm, IndX, Imm, IndX, Zpg, Zpg, Zpg, Zpg, Imp, Imm, Imp, Imm, Abs, Abs, Abs, Abs,
	Rlt, IndY, Imp, IndY, ZpgX, ZpgX, ZpgY, ZpgY, Imp, AbsY, Imp, AbsY, AbsX, AbsX, AbsY, AbsY,
	Imm, IndX, Imm, IndX, Zpg, Zpg, Zpg, Zpg, Imp, Imm, Imp, Imm, Abs, Abs, Abs, Abs,
	Rlt, IndY, Imp, IndY, ZpgX, ZpgX, ZpgX, ZpgX, Imp, AbsY, Imp, AbsY, AbsX, AbsX, AbsX, AbsX,
	Imm, IndX, Imm, IndX, Zpg, Zpg, Zpg, Zpg, Imp, Imm, Imp, Imm, Abs, Abs, Abs, Abs,
	Rlt, IndY, Imp, IndY, ZpgX, ZpgX, ZpgX, ZpgX, Imp, AbsY, Imp, AbsY, AbsX, AbsX, AbsX, AbsX
};

assign opcode = opTable[ins];
assign mode = modeTable[ins];

always_comb
begin
	case (mode)
	Imp:
		pcBytes = 2'd1;
	Ind, Abs, AbsX, AbsY:
		pcBytes = 2'd3;	// 16-bit operand
	default:
		pcBytes = 2'd2;
	endcase
end

endmodule

// File: rtl/fetchSeq.sv
`timescale 1ns/1ps

module fetchSeq (
	input logic clk,
	input logic rstN,
	input logic hold,
	input logic jumpEn,
	input cpuPkg::addrLogic jumpAddr,
	input cpuPkg::dataLogic memData,
	input cpuPkg::Opcode opcode,
	input cpuPkg::Addressing mode,
	input logic [1:0] pcBytes,
	output logic memRd,
	output cpuPkg::addrLogic memAddr,
	output cpuPkg::dataLogic insByte,
	output cpuPkg::addrLogic insAddr,
	output logic [15:0] operand,
	output logic [1:0] length,
	output cpuPkg::Opcode opLatched,
	output cpuPkg::Addressing modeLatched,
	output logic done,
	output logic halted
);

import cpuPkg::*;

typedef enum logic [1:0] {
	Idle,
	WaitOpcode,
	WaitOperand,
	Halt
} FetchState;

FetchState state;
FetchState nextState;
addrLogic pc;
addrLogic jumpTarget;
logic jumpPending;
logic [1:0] cnt;	// bytes already received
addrLogic addrReg;
dataLogic byteReg;
dataLogic loReg;
dataLogic hiReg;
Opcode opReg;
Addressing modeReg;
logic [1:0] lenReg;
logic atOpcode;
logic lastByte;
logic startFetch;
logic applyJump;
logic takeLo;
logic takeHi;

assign atOpcode = state == WaitOpcode;
assign lastByte = state == WaitOperand && cnt + 2'd1 == lenReg;
assign applyJump = state == Idle && !hold && jumpPending;
assign startFetch = state == Idle && !hold && !jumpPending;
assign takeLo = state == WaitOperand && cnt == 2'd1;
assign takeHi = state == WaitOperand && cnt == 2'd2;

always_comb
begin
	nextState = state;
	memRd = 1'b0;
	done = 1'b0;
	case (state)
	Idle:
	begin
		memRd = startFetch;
		if (startFetch)
			nextState = WaitOpcode;
	end
	WaitOpcode:
	begin
		if (pcBytes == 2'd1)
		begin
			done = 1'b1;
			nextState = (opcode == KIL) ? Halt : Idle;
		end
		else
		begin
			memRd = 1'b1;	// first operand byte
			nextState = WaitOperand;
		end
	end
	WaitOperand:
	begin
		done = lastByte;
		memRd = !lastByte;
		if (lastByte)
			nextState = Idle;
	end
	default:
		nextState = Halt;
	endcase
end

assign memAddr = pc;
assign insAddr = addrReg;
// the byte arriving this cycle is shown before it lands in a register
assign insByte = atOpcode ? memData : byteReg;
assign opLatched = atOpcode ? opcode : opReg;
assign modeLatched = atOpcode ? mode : modeReg;
assign length = atOpcode ? pcBytes : lenReg;
assign operand[7:0] = takeLo ? memData : loReg;
assign operand[15:8] = takeHi ? memData : hiReg;

always_ff @(posedge clk or negedge rstN)
begin
	if (!rstN)
	begin
		state <= Idle;
		pc <= resetPc;
		cnt <= 2'd0;
		jumpPending <= 1'b1;	// first boundary loads the start address
		jumpTarget <= resetPc;
		halted <= 1'b0;
	end
	else
	begin
		state <= nextState;
		if (memRd)
			pc <= pc + 16'd1;
		else if (applyJump)
			pc <= jumpTarget;
		if (jumpEn)
		begin
			jumpPending <= 1'b1;
			jumpTarget <= jumpAddr;
		end
		else if (applyJump)
			jumpPending <= 1'b0;
		if (atOpcode)
			cnt <= 2'd1;
		else if (state == WaitOperand)
			cnt <= cnt + 2'd1;
		if (nextState == Halt)
			halted <= 1'b1;
	end
end

always_ff @(posedge clk)
begin
	if (startFetch)
	begin
		addrReg <= pc;
		loReg <= 8'h00;
		hiReg <= 8'h00;
	end
	if (atOpcode)
	begin
		byteReg <= memData;
		opReg <= opcode;
		modeReg <= mode;
		lenReg <= pcBytes;
	end
	if (takeLo)
		loReg <= memData;	// little endian
	if (takeHi)
		hiReg <= memData;
end

endmodule

// File: rtl/targetCalc.sv
`timescale 1ns/1ps

module targetCalc (
	input logic clk,
	input logic rstN,
	input logic done,
	input cpuPkg::Addressing mode,
	input logic [15:0] operand,
	input cpuPkg::addrLogic insAddr,
	output cpuPkg::addrLogic target,
	output logic insValid
);

import cpuPkg::*;

addrLogic offset;
addrLogic nextTarget;

assign offset = {{8{operand[7]}}, operand[7:0]};

always_comb
begin
	case (mode)
	Zpg, ZpgX, ZpgY, IndX, IndY:
		nextTarget = {8'h00, operand[7:0]};
	Abs, AbsX, AbsY, Ind:
		nextTarget = operand;
	Rlt:
		nextTarget = insAddr + 16'd2 + offset;	// from the following instruction
	default:
		nextTarget = 16'h0000;
	endcase
end

always_ff @(posedge clk)
begin
	if (done)
		target <= nextTarget;
end

always_ff @(posedge clk or negedge rstN)
begin
	if (!rstN)
		insValid <= 1'b0;
	else
		insValid <= done;
end

endmodule

// File: rtl/frontEnd.sv
`timescale 1ns/1ps

module frontEnd (
	input logic clk,
	input logic rstN,
	input logic hold,
	input logic jumpEn,
	input cpuPkg::addrLogic jumpAddr,
	input cpuPkg::dataLogic memData,
	output logic memRd,
	output cpuPkg::addrLogic memAddr,
	output logic insValid,
	output cpuPkg::addrLogic insAddr,
	output cpuPkg::dataLogic insByte,
	output cpuPkg::Opcode opcode,
	output cpuPkg::Addressing mode,
	output logic [15:0] operand,
	output logic [1:0] length,
	output cpuPkg::addrLogic target,
	output logic halted
);

import cpuPkg::*;

Opcode decOpcode;
Addressing decMode;
logic [1:0] decBytes;
logic done;

fetchSeq fetch0 (
	.clk(clk),
	.rstN(rstN),
	.hold(hold),
	.jumpEn(jumpEn),
	.jumpAddr(jumpAddr),
	.memData(memData),
	.opcode(decOpcode),
	.mode(decMode),
	.pcBytes(decBytes),
	.memRd(memRd),
	.memAddr(memAddr),
	.insByte(insByte),
	.insAddr(insAddr),
	.operand(operand),
	.length(length),
	.opLatched(opcode),
	.modeLatched(mode),
	.done(done),
	.halted(halted)
);

// decodes the byte on its way in
idec dec0 (
	.ins(insByte),
	.opcode(decOpcode),
	.mode(decMode),
	.pcBytes(decBytes)
);

targetCalc tgt0 (
	.clk(clk),
	.rstN(rstN),
	.done(done),
	.mode(mode),
	.operand(operand),
	.insAddr(insAddr),
	.target(target),
	.insValid(insValid)
);

endmodule

// File: tests/tbFrontEnd.sv
`timescale 1ns/1ps

module tbFrontEnd;

import cpuPkg::*;

logic clk;
logic rstN;
logic hold;
logic jumpEn;
addrLogic jumpAddr;
dataLogic memData;
logic memRd;
addrLogic memAddr;
logic insValid;
addrLogic insAddr;
dataLogic insByte;
Opcode opcode;
Addressing mode;
logic [15:0] operand;
logic [1:0] length;
addrLogic target;
logic halted;

dataLogic mem [65536];
logic rdPend;
addrLogic rdAddr;
logic [15:0] rec [64][7];	// addr byte opcode mode length operand target
int nRec;
int holdStart [$];
int holdLen [$];
int jumpIdx;
addrLogic jumpTo;
int holdHits;
logic holdQuiet;

frontEnd dut0 (.*);

initial
begin
	clk = 1'b0;
	forever
		#2 clk = ~clk;
end

// memory answers one cycle after the read
always @(posedge clk)
begin
	rdPend <= memRd;
	rdAddr <= memAddr;
end

always @(negedge clk)
	memData = rdPend ? mem[rdAddr] : 8'h00;

task automatic abortRun(input string why);
	$display("%s", why);
	$display("RESULT: FAIL");
	$fatal(1);
endtask

task automatic checkVal(input string name, input logic [15:0] expVal,
	input logic [15:0] actVal);
	if (actVal !== expVal)
		abortRun($sformatf("mismatch %s expected %h actual %h", name, expVal, actVal));
endtask

task automatic waitValid(input int idx);
	int n;
	n = 0;
	do
	begin
		@(posedge clk);
		n++;
		if (!insValid)
			checkVal($sformatf("rec%0d halted early", idx), 0, halted);
	end
	while (!insValid && n < 200);
	if (!insValid)
		abortRun($sformatf("no instruction arrived for record %0d within 200 cycles", idx));
endtask

function automatic logic inHold(input int cyc);
	logic on;
	on = 1'b0;
	foreach (holdStart[k])
		if (cyc >= holdStart[k] && cyc < holdStart[k] + holdLen[k])
			on = 1'b1;
	return on;
endfunction

initial
begin : holdDrive
	int cyc;
	cyc = 0;
	repeat (8) @(negedge clk);	// until reset release
	forever
	begin
		@(negedge clk);
		cyc++;
		hold = inHold(cyc);
	end
end

// once a boundary is held, no read may go out until hold drops
always @(posedge clk)
begin
	if (!hold)
		holdQuiet = 1'b0;
	else if (insValid && !holdQuiet)
	begin
		holdQuiet = 1'b1;
		holdHits++;
	end
	if (holdQuiet)
		checkVal("memRd under hold", 0, memRd);
end

initial
begin : mainFlow
	int fd;
	int n;
	int i;
	byte tag;
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] expAddr;
	reg [8*128-1:0] lineBuf;
	rstN = 1'b0;
	hold = 1'b0;
	jumpEn = 1'b0;
	jumpAddr = 16'h0000;
	memData = 8'h00;
	nRec = 0;
	jumpIdx = -1;
	jumpTo = 16'h0000;
	holdHits = 0;
	holdQuiet = 1'b0;
	for (i = 0; i < 65536; i++)
		mem[i] = i[15:8] ^ i[7:0] ^ 8'h5a;
	fd = $fopen("tests/frontEndStim.txt", "r");
	if (fd == 0)
		abortRun("could not open the stimulus file tests/frontEndStim.txt");
	while (!$feof(fd))
	begin
		n = $fscanf(fd, " %c", tag);
		if (n == 1)
			case (tag)
			"M":
			begin
				n = $fscanf(fd, "%h %h", a, b);
				mem[a] = b[7:0];
			end
			"H":
			begin
				n = $fscanf(fd, "%d %d", a, b);
				holdStart.push_back(a);
				holdLen.push_back(b);
			end
			"J":
				n = $fscanf(fd, "%d %h", jumpIdx, jumpTo);
			"E":
			begin
				n = $fscanf(fd, "%h %h %h %h %h %h %h", rec[nRec][0], rec[nRec][1],
					rec[nRec][2], rec[nRec][3], rec[nRec][4], rec[nRec][5], rec[nRec][6]);
				nRec++;
			end
			default:
				n = $fgets(lineBuf, fd);	// comment line
			endcase
	end
	$fclose(fd);

	repeat (8) @(negedge clk);
	rstN = 1'b1;

	for (i = 0; i < nRec; i++)
	begin
		waitValid(i);
		if (i == 0)
			expAddr = resetPc;
		else
			expAddr = rec[i-1][0] + rec[i-1][4];	// previous address plus length
		if (jumpIdx >= 0 && i == jumpIdx + 2)
			expAddr = jumpTo;
		checkVal($sformatf("rec%0d addr chain", i), expAddr, insAddr);
		checkVal($sformatf("rec%0d insAddr", i), rec[i][0], insAddr);
		checkVal($sformatf("rec%0d insByte", i), rec[i][1], insByte);
		checkVal($sformatf("rec%0d opcode", i), rec[i][2], opcode);
		checkVal($sformatf("rec%0d mode", i), rec[i][3], mode);
		checkVal($sformatf("rec%0d length", i), rec[i][4], length);
		checkVal($sformatf("rec%0d operand", i), rec[i][5], operand);
		checkVal($sformatf("rec%0d target", i), rec[i][6], target);
		if (rec[i][4] < 3)
			checkVal($sformatf("rec%0d operand high", i), 0, operand[15:8]);
		checkVal($sformatf("rec%0d halted", i), i == nRec - 1, halted);
		if (i == jumpIdx)
		begin
			@(negedge clk);
			jumpAddr = jumpTo;
			jumpEn = 1'b1;
			@(negedge clk);
			jumpEn = 1'b0;
		end
	end

	repeat (20)
	begin
		@(posedge clk);
		checkVal("memRd after halt", 0, memRd);
		checkVal("insValid after halt", 0, insValid);
		checkVal("halted after halt", 1, halted);
	end
	checkVal("held boundaries", holdStart.size(), holdHits);
	$display("RESULT: PASS");
	$finish;
end

endmodule

// File: filelist.f
rtl/cpuPkg.sv
rtl/idec.sv
rtl/fetchSeq.sv
rtl/targetCalc.sv
rtl/frontEnd.sv
tests/tbFrontEnd.sv

// File: tests/frontEndStim.txt
# M addr byte | H start len (decimal cycles after reset) | J index(decimal) addr
# E addr byte opcode mode length operand target, all hex
M 0200 a9
M 0201 42
M 0202 8d
M 0203 34
M 0204 12
M 0205 e8
M 0206 d0
M 0207 04
M 0208 a5
M 0209 80
M 020a f0
M 020b f4
M 020c 02
M 0400 6c
M 0401 00
M 0402 03
M 0403 02
H 6 6
H 27 4
J 4 0400
E 0200 a9 1d 1 2 0042 0000
E 0202 8d 2f 8 3 1234 1234
E 0205 e8 19 0 1 0000 0000
E 0206 d0 08 b 2 0004 020c
E 0208 a5 1d 5 2 0080 0080
E 020a f0 05 b 2 00f4 0200
E 0400 6c 1b 2 3 0300 0300
E 0403 02 4a 0 1 0000 0000
